// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= l2_cache_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the simulation printed the pass line.
run: build
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
+incdir+hw
hw/lc3b_types.sv
hw/l2_cache_array.sv
hw/l2_cache_control.sv
hw/l2_ewb.sv
hw/l2_cache.sv
tests/l2_cache_assertions.sv
tests/l2_cache_checker.sv
tests/l2_cache_tb.sv

// ==== hw/l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache
    import lc3b_types::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire lc3b_l2_req  mem_req,
    output lc3b_c_line       mem_rdata,
    output logic             mem_resp,
    output lc3b_word         pmem_address,
    output logic             pmem_read,
    output logic             pmem_write,
    output lc3b_c_line       pmem_wdata,
    input  wire lc3b_c_line  pmem_rdata,
    input  wire logic        pmem_resp
);

    logic hit;
    logic victim_dirty;
    logic ld_line;
    logic fill_sel;
    logic ld_lru;
    logic set_dirty;
    logic clear_dirty;
    logic ewb_load;
    logic refill_read;
    logic ewb_empty;
    logic refill_resp;
    lc3b_c_line victim_line;
    lc3b_word victim_address;
    lc3b_word refill_address;

    l2_cache_array array (
        .clk            (clk),
        .rst            (rst),
        .req            (mem_req),
        .pmem_rdata     (pmem_rdata),
        .ld_line        (ld_line),
        .fill_sel       (fill_sel),
        .ld_lru         (ld_lru),
        .set_dirty      (set_dirty),
        .clear_dirty    (clear_dirty),
        .hit            (hit),
        .victim_dirty   (victim_dirty),
        .hit_way        (),
        .lru_way        (),
        .rdata          (mem_rdata),
        .victim_line    (victim_line),
        .victim_address (victim_address)
    );

    l2_cache_control control (
        .clk            (clk),
        .rst            (rst),
        .req            (mem_req),
        .hit            (hit),
        .victim_dirty   (victim_dirty),
        .ewb_empty      (ewb_empty),
        .refill_resp    (refill_resp),
        .ld_line        (ld_line),
        .fill_sel       (fill_sel),
        .ld_lru         (ld_lru),
        .set_dirty      (set_dirty),
        .clear_dirty    (clear_dirty),
        .ewb_load       (ewb_load),
        .refill_read    (refill_read),
        .mem_resp       (mem_resp),
        .refill_address (refill_address)
    );

    l2_ewb ewb (
        .clk            (clk),
        .rst            (rst),
        .ewb_load       (ewb_load),
        .refill_read    (refill_read),
        .victim_line    (victim_line),
        .victim_address (victim_address),
        .refill_address (refill_address),
        .pmem_resp      (pmem_resp),
        .ewb_empty      (ewb_empty),
        .refill_resp    (refill_resp),
        .pmem_address   (pmem_address),
        .pmem_read      (pmem_read),
        .pmem_write     (pmem_write),
        .pmem_wdata     (pmem_wdata)
    );

endmodule : l2_cache

`default_nettype wire

// ==== hw/l2_cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_consts.svh"

module l2_cache_array
    import lc3b_types::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire lc3b_l2_req   req,
    input  wire lc3b_c_line   pmem_rdata,
    input  wire logic         ld_line,
    input  wire logic         fill_sel,
    input  wire logic         ld_lru,
    input  wire logic         set_dirty,
    input  wire logic         clear_dirty,
    output logic              hit,
    output logic              victim_dirty,
    output lc3b_c_l2_way      hit_way,
    output lc3b_c_l2_way      lru_way,
    output lc3b_c_line        rdata,
    output lc3b_c_line        victim_line,
    output lc3b_word          victim_address
);

    logic [`L2_WAYS-1:0] valid [`L2_SETS];
    logic [`L2_WAYS-1:0] dirty [`L2_SETS];
    logic [2:0] lru [`L2_SETS];  // [0] is the tree root.
    lc3b_c_l2_tag tags [`L2_SETS][`L2_WAYS];
    lc3b_c_line lines [`L2_SETS][`L2_WAYS];

    logic [`L2_SET_BITS-1:0] set_idx;
    logic [2:0] tree;
    lc3b_c_l2_way ld_way;
    lc3b_c_line line_in;
    lc3b_c_l2_addr victim_addr;

    assign set_idx = req.address.f.set;
    assign tree = lru[set_idx];

    // parallel tag compare.
    always_comb
    begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (valid[set_idx][w] && tags[set_idx][w] == req.address.f.tag)
            begin
                hit = 1'b1;
                hit_way = 2'(w);
            end
        end
    end

    // follow the tree toward the least recent side.
    assign lru_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

    assign victim_dirty = valid[set_idx][lru_way] & dirty[set_idx][lru_way];
    assign victim_line = lines[set_idx][lru_way];
    assign rdata = lines[set_idx][hit_way];

    always_comb
    begin
        victim_addr.f.tag = tags[set_idx][lru_way];
        victim_addr.f.set = set_idx;
        victim_addr.f.offset = '0;
    end

    assign victim_address = victim_addr.word;

    assign ld_way = hit ? hit_way : lru_way;
    assign line_in = fill_sel ? pmem_rdata : req.wdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < `L2_SETS; s++)
            begin
                valid[s] <= '0;
                dirty[s] <= '0;
                lru[s] <= '0;
            end
        end
        else
        begin
            if (ld_line)
            begin
                valid[set_idx][ld_way] <= 1'b1;
                if (set_dirty)
                    dirty[set_idx][ld_way] <= 1'b1;
                else if (clear_dirty)
                    dirty[set_idx][ld_way] <= 1'b0;
            end
            if (ld_lru)
            begin
                lru[set_idx][0] <= ~hit_way[1];  // point at the other pair.
                if (hit_way[1])
                    lru[set_idx][2] <= ~hit_way[0];
                else
                    lru[set_idx][1] <= ~hit_way[0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ld_line)
        begin
            tags[set_idx][ld_way] <= req.address.f.tag;
            lines[set_idx][ld_way] <= line_in;
        end
    end

endmodule : l2_cache_array

`default_nettype wire

// ==== hw/l2_cache_consts.svh ====
`ifndef L2_CACHE_CONSTS_SVH
`define L2_CACHE_CONSTS_SVH

// cache geometry.
`define L2_WAYS 4
`define L2_SETS 16
`define L2_LINE_BITS 256

// tag in [15:9], set in [8:5] and byte offset in [4:0].
`define L2_TAG_BITS 7
`define L2_SET_BITS 4
`define L2_OFFSET_BITS 5

`endif

// ==== hw/l2_cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_consts.svh"

module l2_cache_control
    import lc3b_types::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire lc3b_l2_req  req,
    input  wire logic        hit,
    input  wire logic        victim_dirty,
    input  wire logic        ewb_empty,
    input  wire logic        refill_resp,
    output logic             ld_line,
    output logic             fill_sel,
    output logic             ld_lru,
    output logic             set_dirty,
    output logic             clear_dirty,
    output logic             ewb_load,
    output logic             refill_read,
    output logic             mem_resp,
    output lc3b_word         refill_address
);

    typedef enum logic [1:0] {
        idle,
        hit_resp,
        evict,
        fill
    } state_t;

    state_t state;
    state_t next_state;
    lc3b_c_l2_addr line_addr;

    // refill always fetches the whole line.
    always_comb
    begin
        line_addr = req.address;
        line_addr.f.offset = '0;
    end

    assign refill_address = line_addr.word;

    always_comb
    begin
        ld_line = 1'b0;
        fill_sel = 1'b0;
        ld_lru = 1'b0;
        set_dirty = 1'b0;
        clear_dirty = 1'b0;
        ewb_load = 1'b0;
        refill_read = 1'b0;
        mem_resp = 1'b0;

        case (state)
            hit_resp:
            begin
                mem_resp = 1'b1;
                ld_lru = 1'b1;
                if (req.write)
                begin
                    ld_line = 1'b1;  // whole line from the L1.
                    set_dirty = 1'b1;
                end
            end

            evict:
            begin
                ewb_load = 1'b1;  // victim is still in the array here.
                refill_read = 1'b1;
            end

            fill:
            begin
                refill_read = 1'b1;
                if (refill_resp)
                begin
                    ld_line = 1'b1;
                    fill_sel = 1'b1;
                    clear_dirty = 1'b1;
                end
            end

            default:
            begin
            end
        endcase
    end

    always_comb
    begin
        next_state = state;

        case (state)
            idle:
            begin
                if (req.read || req.write)
                begin
                    if (hit)
                        next_state = hit_resp;
                    else if (!victim_dirty)
                        next_state = fill;
                    else if (ewb_empty)
                        next_state = evict;
                    // otherwise wait for the buffer to drain.
                end
            end

            hit_resp:
                next_state = idle;

            evict:
                next_state = fill;

            fill:
            begin
                if (refill_resp)
                    next_state = idle;  // replays as a hit.
            end

            default:
                next_state = idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= idle;
        else
            state <= next_state;
    end

endmodule : l2_cache_control

`default_nettype wire

// ==== hw/l2_ewb.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_ewb
    import lc3b_types::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        ewb_load,
    input  wire logic        refill_read,
    input  wire lc3b_c_line  victim_line,
    input  wire lc3b_word    victim_address,
    input  wire lc3b_word    refill_address,
    input  wire logic        pmem_resp,
    output logic             ewb_empty,
    output logic             refill_resp,
    output lc3b_word         pmem_address,
    output logic             pmem_read,
    output logic             pmem_write,
    output lc3b_c_line       pmem_wdata
);

    typedef enum logic [1:0] {
        idle,
        reading,
        writing
    } port_state_t;

    port_state_t state;
    logic full;
    lc3b_c_line buf_line;
    lc3b_word buf_address;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= idle;
            full <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (refill_read)
                        state <= reading;  // refill wins the port.
                    else if (full)
                        state <= writing;
                end
                reading:
                    if (pmem_resp)
                        state <= idle;
                writing:
                begin
                    if (pmem_resp)
                    begin
                        state <= idle;
                        full <= 1'b0;
                    end
                end
                default:
                    state <= idle;
            endcase
            if (ewb_load)
                full <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ewb_load)
        begin
            buf_line <= victim_line;
            buf_address <= victim_address;
        end
    end

    assign ewb_empty = ~full;
    assign refill_resp = (state == reading) && pmem_resp;
    assign pmem_read = (state == reading);
    assign pmem_write = (state == writing);
    assign pmem_address = (state == writing) ? buf_address : refill_address;
    assign pmem_wdata = buf_line;

endmodule : l2_ewb

`default_nettype wire

// ==== hw/lc3b_types.sv ====
`default_nettype none

`include "l2_cache_consts.svh"

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [`L2_LINE_BITS-1:0] lc3b_c_line;
    typedef logic [`L2_TAG_BITS-1:0] lc3b_c_l2_tag;
    typedef logic [1:0] lc3b_c_l2_way;

    // field view of an address.
    typedef struct packed {
        lc3b_c_l2_tag tag;
        logic [`L2_SET_BITS-1:0] set;
        logic [`L2_OFFSET_BITS-1:0] offset;
    } lc3b_c_l2_fields;

    // same 16 bits as a raw word or as fields.
    typedef union packed {
        lc3b_word word;
        lc3b_c_l2_fields f;
    } lc3b_c_l2_addr;

    // L1 side request held until mem_resp.
    typedef struct packed {
        logic read;
        logic write;
        lc3b_c_l2_addr address;
        lc3b_c_line wdata;
    } lc3b_l2_req;

endpackage : lc3b_types

`default_nettype wire

// ==== tests/l2_cache_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_assertions
    import lc3b_types::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      mem_resp,
    input  wire logic      pmem_read,
    input  wire logic      pmem_write,
    input  wire logic      pmem_resp,
    input  wire lc3b_word  pmem_address
);

    int fail_count = 0;

    one_op: assert property (@(posedge clk) !(pmem_read && pmem_write))
    else
    begin
        $error("pmem_read and pmem_write are high together");
        fail_count = fail_count + 1;
    end

    // held request keeps its address.
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        (pmem_read || pmem_write) && !pmem_resp |=> $stable(pmem_address))
    else
    begin
        $error("pmem_address changed while a request was held");
        fail_count = fail_count + 1;
    end

    resp_pulse: assert property (@(posedge clk) disable iff (rst) mem_resp |=> !mem_resp)
    else
    begin
        $error("mem_resp lasted more than one cycle");
        fail_count = fail_count + 1;
    end

    reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> !mem_resp && !pmem_read && !pmem_write)
    else
    begin
        $error("request or response active during or just after reset");
        fail_count = fail_count + 1;
    end

endmodule : l2_cache_assertions

bind l2_cache l2_cache_assertions protocol_checks (
    .clk          (clk),
    .rst          (rst),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_resp    (pmem_resp),
    .pmem_address (pmem_address)
);

`default_nettype wire

// ==== tests/l2_cache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_consts.svh"

module l2_cache_checker
    import lc3b_types::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire lc3b_l2_req  mem_req,
    input  wire lc3b_c_line  mem_rdata,
    input  wire logic        mem_resp,
    input  wire lc3b_word    pmem_address,
    input  wire logic        pmem_write,
    input  wire lc3b_c_line  pmem_wdata,
    input  wire logic        pmem_resp,
    output int               mismatches,
    output int               other_errors
);

    lc3b_c_line shadow [lc3b_word];  // last L1 write per line.
    logic busy;
    int waited;
    lc3b_word answered;
    logic answered_valid;

    function automatic lc3b_word align(input lc3b_word addr);
        return {addr[15:`L2_OFFSET_BITS], {`L2_OFFSET_BITS{1'b0}}};
    endfunction

    function automatic lc3b_c_line expected_line(input lc3b_word line_addr);
        if (shadow.exists(line_addr))
            return shadow[line_addr];
        return {16{line_addr}};
    endfunction

    task automatic check_writeback();
        if (pmem_address !== align(pmem_address))
        begin
            $display("Mismatch pmem_address: expected %h, got %h", align(pmem_address),
                     pmem_address);
            mismatches++;
        end
        else if (pmem_wdata !== expected_line(pmem_address))
        begin
            $display("Mismatch pmem_wdata at %h: expected %h, got %h", pmem_address,
                     expected_line(pmem_address), pmem_wdata);
            mismatches++;
        end
    endtask

    task automatic check_response();
        lc3b_word line;
        line = align(mem_req.address.word);
        if (!busy)
        begin
            $display("mem_resp came with no request pending");
            other_errors++;
        end
        else
        begin
            if (mem_req.read && mem_rdata !== expected_line(line))
            begin
                $display("Mismatch mem_rdata at %h: expected %h, got %h", line,
                         expected_line(line), mem_rdata);
                mismatches++;
            end
            if (mem_req.write)
                shadow[line] = mem_req.wdata;
            if (answered_valid && mem_req.address.word == answered && waited != 2)
            begin
                $display("Mismatch mem_resp latency: expected %h, got %h", 2, waited);
                mismatches++;
            end
            answered = mem_req.address.word;
            answered_valid = 1'b1;
            busy = 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            busy = 1'b0;
            waited = 0;
            answered_valid = 1'b0;
            mismatches = 0;
            other_errors = 0;
        end
        else
        begin
            if (mem_req.read || mem_req.write)
            begin
                waited = busy ? waited + 1 : 1;  // first cycle seen counts as one.
                busy = 1'b1;
            end
            if (pmem_write && pmem_resp)
                check_writeback();
            if (mem_resp)
                check_response();
        end
    end

endmodule : l2_cache_checker

`default_nettype wire

// ==== tests/l2_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb
    import lc3b_types::*;
();

    localparam int RANDOM_ACCESSES = 368;
    localparam int LINES = 32;  // 8 tags in 4 sets.
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = (RANDOM_ACCESSES + LINES) * 40 + RESET_CYCLES;

    logic clk;
    logic rst;
    lc3b_l2_req mem_req;
    lc3b_c_line mem_rdata;
    logic mem_resp;
    lc3b_word pmem_address;
    logic pmem_read;
    logic pmem_write;
    lc3b_c_line pmem_wdata;
    lc3b_c_line pmem_rdata = '0;
    logic pmem_resp = 1'b0;

    integer seed = 32'hbcf2_a1d2;
    int cycles = 0;
    int mem_wait = 0;
    int mismatches;
    int other_errors;
    lc3b_word last_addr;
    lc3b_c_line pmem [lc3b_word];

    l2_cache DUT (
        .clk          (clk),
        .rst          (rst),
        .mem_req      (mem_req),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    l2_cache_checker monitor (
        .clk          (clk),
        .rst          (rst),
        .mem_req      (mem_req),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .pmem_resp    (pmem_resp),
        .mismatches   (mismatches),
        .other_errors (other_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    function automatic lc3b_word line_address(input int idx);
        lc3b_c_l2_addr a;
        a.f.tag = {idx[4:2], 4'h5};
        a.f.set = {idx[1:0], 2'b10};
        a.f.offset = '0;
        return a.word;
    endfunction

    // holds the request until mem_resp, then drops it.
    task automatic access(input logic write, input lc3b_word addr, input lc3b_c_line data);
        mem_req.read = ~write;
        mem_req.write = write;
        mem_req.address.word = addr;
        mem_req.wdata = data;
        @(posedge clk);
        while (!mem_resp)
            @(posedge clk);
        #1;
        mem_req = '0;
        last_addr = addr;
    endtask

    task automatic random_access();
        logic [31:0] r;
        lc3b_word addr;
        lc3b_c_line data;
        r = $random(seed);
        for (int k = 0; k < 8; k++)
            data[k*32 +: 32] = $random(seed);
        if (r[2:0] == 3'd0)
            addr = last_addr;  // same address again.
        else
            addr = line_address(int'(r[7:3])) | {11'b0, r[12:8]};
        access(r[13], addr, data);
    endtask

    // physical memory with a 1 to 6 cycle response.
    always @(posedge clk)
    begin
        logic [31:0] r;
        logic respond;
        logic wr;
        lc3b_word addr;
        lc3b_c_line data;
        respond = 1'b0;
        wr = pmem_write;
        addr = pmem_address;
        data = pmem_wdata;
        if (rst || pmem_resp)
            mem_wait = 0;
        else if (pmem_read || pmem_write)
        begin
            if (mem_wait == 0)
            begin
                r = $random(seed);
                mem_wait = 1 + int'(r[7:0]) % 6;
            end
            mem_wait = mem_wait - 1;
            respond = (mem_wait == 0);
        end
        #1;
        if (respond && wr)
            pmem[addr] = data;
        else if (respond)
            pmem_rdata = pmem.exists(addr) ? pmem[addr] : {16{addr}};
        pmem_resp = respond;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial
    begin
        int total;
        rst = 1'b1;
        mem_req = '0;
        last_addr = line_address(0);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < RANDOM_ACCESSES; i++)
            random_access();
        for (int i = 0; i < LINES; i++)
            access(1'b0, line_address(i), '0);  // read back every line.
        @(negedge clk);
        total = mismatches + other_errors + DUT.protocol_checks.fail_count;
        $display("errors: %0d mismatches, %0d other, %0d assertion", mismatches,
                 other_errors, DUT.protocol_checks.fail_count);
        if (total == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule : l2_cache_tb

`default_nettype wire
